// ==== rtl/grid_pkg.sv ====
package grid_pkg;

    // grid geometry
    localparam int GRID_ROWS = 16;
    localparam int ROW_BITS = 64;
    localparam int SEG_WIDTH = 8;
    localparam int SEGS_PER_ROW = ROW_BITS / SEG_WIDTH;

    localparam int ROW_ADDR_WIDTH = $clog2(GRID_ROWS);
    localparam int SEG_ADDR_WIDTH = $clog2(SEGS_PER_ROW);

    // even rows in one bank, odd rows in the other
    localparam int BANK_DEPTH = GRID_ROWS / 2;
    localparam int BANK_ADDR_WIDTH = $clog2(BANK_DEPTH);

    // word address is {row, segment}
    localparam int BUS_ADDR_WIDTH = ROW_ADDR_WIDTH + SEG_ADDR_WIDTH;

    // low lane carries row r, high lane row r+1
    localparam int BUS_DATA_WIDTH = 2 * SEG_WIDTH;

    // request presented to one bank
    typedef enum logic [1:0] {
        BANK_NOP   = 2'd0,
        BANK_READ  = 2'd1,
        BANK_WRITE = 2'd2
    } bank_op_t;

    // bank controller states
    typedef enum logic {
        BANK_IDLE   = 1'b0,
        BANK_ACCESS = 1'b1
    } bank_state_t;

endpackage

// ==== rtl/bank_if.sv ====
`timescale 1ns/1ps

interface bank_if import grid_pkg::*; ();

    // request side, held until ack
    bank_op_t op;
    logic [BANK_ADDR_WIDTH-1:0] row_addr;
    logic [SEG_ADDR_WIDTH-1:0] seg_addr;
    logic [SEG_WIDTH-1:0] wdata;

    // answer side
    logic [SEG_WIDTH-1:0] rdata;
    logic ack;

    modport requester (
        output op,
        output row_addr,
        output seg_addr,
        output wdata,
        input rdata,
        input ack
    );

    modport bank (
        input op,
        input row_addr,
        input seg_addr,
        input wdata,
        output rdata,
        output ack
    );

endinterface

// ==== rtl/segment_ram.sv ====
`timescale 1ns/1ps

module segment_ram import grid_pkg::*; (
    input logic clock,
    input logic [BANK_ADDR_WIDTH-1:0] row_addr,
    input logic [SEGS_PER_ROW-1:0] seg_wen,
    input logic [SEG_WIDTH-1:0] wdata,
    output logic [ROW_BITS-1:0] rdata
);

    logic [ROW_BITS-1:0] mem [BANK_DEPTH];

    // byte-lane style write, one enable per segment
    always_ff @(posedge clock) begin
        for (int i = 0; i < SEGS_PER_ROW; i++) begin
            if (seg_wen[i]) begin
                mem[row_addr][i*SEG_WIDTH +: SEG_WIDTH] <= wdata;
            end
        end
    end

    // full row registered, old contents on a same-cycle write
    always_ff @(posedge clock) begin
        rdata <= mem[row_addr];
    end

endmodule

// ==== rtl/row_bank.sv ====
`timescale 1ns/1ps

module row_bank import grid_pkg::*; (
    input logic clock,
    input logic reset,
    bank_if.bank bank
);

    bank_state_t state;
    bank_state_t next_state;

    // per-row dirty list, one bit for each segment of the row
    // so a partly written row still reads zero in its untouched segments
    logic [BANK_DEPTH-1:0][SEGS_PER_ROW-1:0] dirty_list;

    // address being served, latched when the request is taken
    logic [BANK_ADDR_WIDTH-1:0] serve_row;
    logic [SEG_ADDR_WIDTH-1:0] serve_seg;

    logic [SEGS_PER_ROW-1:0] seg_wen;
    logic [ROW_BITS-1:0] ram_row;
    logic start;
    logic start_write;

    segment_ram u_ram (
        .clock(clock),
        .row_addr(bank.row_addr),
        .seg_wen(seg_wen),
        .wdata(bank.wdata),
        .rdata(ram_row)
    );

    // a request is taken only from idle
    assign start = (state == BANK_IDLE) && (bank.op != BANK_NOP);
    assign start_write = (state == BANK_IDLE) && (bank.op == BANK_WRITE);

    // one-hot segment enable, write commits at the accepting edge
    always_comb begin
        seg_wen = '0;
        if (start_write) begin
            seg_wen[bank.seg_addr] = 1'b1;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            BANK_IDLE: begin
                if (start) begin
                    next_state = BANK_ACCESS;
                end
            end
            BANK_ACCESS: begin
                next_state = BANK_IDLE;
            end
            default: begin
                next_state = BANK_IDLE;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= BANK_IDLE;
            dirty_list <= '0;
        end else begin
            state <= next_state;
            if (start_write) begin
                dirty_list[bank.row_addr][bank.seg_addr] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (start) begin
            serve_row <= bank.row_addr;
            serve_seg <= bank.seg_addr;
        end
    end

    // ack exactly for the one access cycle
    assign bank.ack = (state == BANK_ACCESS);

    // segment select from the registered row, zero if never written
    assign bank.rdata = dirty_list[serve_row][serve_seg]
                        ? ram_row[serve_seg*SEG_WIDTH +: SEG_WIDTH]
                        : '0;

endmodule

// ==== rtl/pair_combiner.sv ====
`timescale 1ns/1ps

module pair_combiner import grid_pkg::*; (
    input logic clock,
    input logic reset,
    input logic cyc,
    input logic stb,
    input logic we,
    input logic [BUS_ADDR_WIDTH-1:0] adr,
    input logic [BUS_DATA_WIDTH-1:0] dat_w,
    input logic [1:0] sel,
    output logic [BUS_DATA_WIDTH-1:0] dat_r,
    output logic ack,
    bank_if.requester even_bank,
    bank_if.requester odd_bank
);

    logic [ROW_ADDR_WIDTH-1:0] row;
    logic [ROW_ADDR_WIDTH-1:0] next_row;
    logic [SEG_ADDR_WIDTH-1:0] seg;
    logic odd_row;

    // bank addresses of row r (low lane) and row r+1 (high lane)
    logic [BANK_ADDR_WIDTH-1:0] lo_addr;
    logic [BANK_ADDR_WIDTH-1:0] hi_addr;

    logic [SEG_WIDTH-1:0] lo_wdata;
    logic [SEG_WIDTH-1:0] hi_wdata;
    bank_op_t lo_op;
    logic req;
    bank_op_t hi_op;

    // high during the ack cycle
    logic in_flight;

    assign row = adr[BUS_ADDR_WIDTH-1 -: ROW_ADDR_WIDTH];
    assign seg = adr[SEG_ADDR_WIDTH-1:0];

    // row 15 wraps to row 0 in the 4-bit add
    assign next_row = row + ROW_ADDR_WIDTH'(1);
    assign odd_row = row[0];

    assign lo_addr = row[ROW_ADDR_WIDTH-1:1];
    assign hi_addr = next_row[ROW_ADDR_WIDTH-1:1];

    assign lo_wdata = dat_w[SEG_WIDTH-1:0];
    assign hi_wdata = dat_w[BUS_DATA_WIDTH-1:SEG_WIDTH];

    assign req = cyc && stb && !in_flight;

    // a lane without sel still reads, so both banks stay in step
    always_comb begin
        lo_op = BANK_NOP;
        hi_op = BANK_NOP;
        if (req) begin
            lo_op = (we && sel[0]) ? BANK_WRITE : BANK_READ;
            hi_op = (we && sel[1]) ? BANK_WRITE : BANK_READ;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            in_flight <= 1'b0;
        end else begin
            in_flight <= req;
        end
    end

    // row r goes to the even bank for an even r and to the odd bank for an odd r
    assign even_bank.op = odd_row ? hi_op : lo_op;
    assign odd_bank.op = odd_row ? lo_op : hi_op;
    assign even_bank.row_addr = odd_row ? hi_addr : lo_addr;
    assign odd_bank.row_addr = odd_row ? lo_addr : hi_addr;
    assign even_bank.seg_addr = seg;
    assign odd_bank.seg_addr = seg;
    assign even_bank.wdata = odd_row ? hi_wdata : lo_wdata;
    assign odd_bank.wdata = odd_row ? lo_wdata : hi_wdata;

    // back into lane order
    assign dat_r = odd_row ? {even_bank.rdata, odd_bank.rdata}
                           : {odd_bank.rdata, even_bank.rdata};

    assign ack = even_bank.ack && odd_bank.ack;

endmodule

// ==== rtl/grid_store_top.sv ====
`timescale 1ns/1ps

module grid_store_top import grid_pkg::*; (
    input logic clock,
    input logic reset,
    input logic cyc,
    input logic stb,
    input logic we,
    input logic [BUS_ADDR_WIDTH-1:0] adr,
    input logic [BUS_DATA_WIDTH-1:0] dat_w,
    input logic [1:0] sel,
    output logic [BUS_DATA_WIDTH-1:0] dat_r,
    output logic ack
);

    // one link per bank
    bank_if even_if ();
    bank_if odd_if ();

    // even grid rows
    row_bank u_even_bank (
        .clock(clock),
        .reset(reset),
        .bank(even_if.bank)
    );

    // odd grid rows
    row_bank u_odd_bank (
        .clock(clock),
        .reset(reset),
        .bank(odd_if.bank)
    );

    pair_combiner u_combiner (
        .clock(clock),
        .reset(reset),
        .cyc(cyc),
        .stb(stb),
        .we(we),
        .adr(adr),
        .dat_w(dat_w),
        .sel(sel),
        .dat_r(dat_r),
        .ack(ack),
        .even_bank(even_if.requester),
        .odd_bank(odd_if.requester)
    );

endmodule

// ==== tb/grid_store_asserts.sv ====
`timescale 1ns/1ps

module grid_store_asserts (
    input logic clock,
    input logic reset,
    input logic cyc,
    input logic stb,
    input logic ack
);

    // slave only answers a request inside a cycle
    ack_rise_needs_request: assert property (
        @(posedge clock) disable iff (reset)
        $rose(ack) |-> $past(cyc && stb)
    ) else $error("ack rose without stb and cyc in the previous cycle");

    // single-cycle pulse
    ack_one_cycle: assert property (
        @(posedge clock) disable iff (reset)
        ack |=> !ack
    ) else $error("ack stayed high for more than one cycle");

    ack_low_after_reset: assert property (
        @(posedge clock)
        reset |=> !ack
    ) else $error("ack high in the cycle after reset");

    // accepted request answered in the next cycle
    ack_follows_request: assert property (
        @(posedge clock) disable iff (reset)
        (cyc && stb && !ack) |=> ack
    ) else $error("accepted request got no ack in the next cycle");

endmodule

bind grid_store_top grid_store_asserts u_asserts (
    .clock(clock),
    .reset(reset),
    .cyc(cyc),
    .stb(stb),
    .ack(ack)
);

// ==== tb/grid_store_tb.sv ====
`timescale 1ns/1ps

module grid_store_tb import grid_pkg::*; ();

    localparam int ACK_TIMEOUT = 20;
    localparam int NUM_STEPS = 21;
    localparam int NUM_RANDOM = 200;

    typedef struct packed {
        logic we;
        logic [ROW_ADDR_WIDTH-1:0] row;
        logic [SEG_ADDR_WIDTH-1:0] seg;
        logic [1:0] sel;
        logic [BUS_DATA_WIDTH-1:0] wdata;
        logic [BUS_DATA_WIDTH-1:0] exp_data;
    } step_t;

    // we, row, seg, sel, write data, expected read (reads only)
    localparam step_t STEPS [NUM_STEPS] = '{
        '{1'b0, 4'd0, 3'd0, 2'b11, 16'h0000, 16'h0000},
        '{1'b0, 4'd7, 3'd5, 2'b11, 16'h0000, 16'h0000},
        '{1'b0, 4'd15, 3'd7, 2'b11, 16'h0000, 16'h0000},
        '{1'b1, 4'd4, 3'd2, 2'b01, 16'h00a5, 16'h0000},
        '{1'b0, 4'd4, 3'd2, 2'b11, 16'h0000, 16'h00a5},
        '{1'b0, 4'd3, 3'd2, 2'b11, 16'h0000, 16'ha500},
        '{1'b1, 4'd15, 3'd6, 2'b11, 16'h3c7e, 16'h0000},
        '{1'b0, 4'd0, 3'd6, 2'b11, 16'h0000, 16'h003c},
        '{1'b0, 4'd14, 3'd6, 2'b11, 16'h0000, 16'h7e00},
        '{1'b0, 4'd15, 3'd6, 2'b11, 16'h0000, 16'h3c7e},
        '{1'b1, 4'd4, 3'd3, 2'b01, 16'h0011, 16'h0000},
        '{1'b1, 4'd4, 3'd1, 2'b10, 16'h5a00, 16'h0000},
        '{1'b0, 4'd4, 3'd2, 2'b11, 16'h0000, 16'h00a5},
        '{1'b0, 4'd4, 3'd3, 2'b11, 16'h0000, 16'h0011},
        '{1'b0, 4'd4, 3'd1, 2'b11, 16'h0000, 16'h5a00},
        '{1'b0, 4'd4, 3'd0, 2'b11, 16'h0000, 16'h0000},
        '{1'b1, 4'd9, 3'd0, 2'b11, 16'hc3e1, 16'h0000},
        '{1'b1, 4'd9, 3'd0, 2'b00, 16'hffff, 16'h0000},
        '{1'b0, 4'd9, 3'd0, 2'b11, 16'h0000, 16'hc3e1},
        '{1'b0, 4'd8, 3'd0, 2'b11, 16'h0000, 16'he100},
        '{1'b0, 4'd10, 3'd0, 2'b11, 16'h0000, 16'h00c3}
    };

    logic clock;
    logic reset;
    logic cyc;
    logic stb;
    logic we;
    logic [BUS_ADDR_WIDTH-1:0] adr;
    logic [BUS_DATA_WIDTH-1:0] dat_w;
    logic [1:0] sel;
    logic [BUS_DATA_WIDTH-1:0] dat_r;
    logic ack;

    // reference grid with one byte per segment
    logic [SEG_WIDTH-1:0] shadow [GRID_ROWS][SEGS_PER_ROW];

    integer seed;

    grid_store_top u_dut (
        .clock(clock),
        .reset(reset),
        .cyc(cyc),
        .stb(stb),
        .we(we),
        .adr(adr),
        .dat_w(dat_w),
        .sel(sel),
        .dat_r(dat_r),
        .ack(ack)
    );

    always #20 clock = ~clock;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "stopped at the first error");
    endtask

    // counts idle cycles before ack on falling edges
    task automatic wait_ack(output int idle);
        idle = 0;
        @(negedge clock);
        while (!ack && idle < ACK_TIMEOUT) begin
            idle++;
            @(negedge clock);
        end
        if (!ack) begin
            report_failure($sformatf("ack never came within %0d cycles for address 0x%02h",
                ACK_TIMEOUT, adr));
        end
    endtask

    task automatic check_ack_timing(input int idle);
        assert (idle == 1) else
            report_failure($sformatf("CHECK FAILED ack: 0x%0h idle cycles, expected 0x1", idle));
    endtask

    task automatic check_single_pulse();
        @(negedge clock);
        assert (!ack) else
            report_failure($sformatf("CHECK FAILED ack: 0x%0h after the pulse, expected 0x0", ack));
    endtask

    task automatic check_read(input logic [ROW_ADDR_WIDTH-1:0] row,
            input logic [SEG_ADDR_WIDTH-1:0] seg, input logic [BUS_DATA_WIDTH-1:0] got,
            input logic [BUS_DATA_WIDTH-1:0] expected);
        assert (got == expected) else
            report_failure($sformatf(
                "CHECK FAILED dat_r: row 0x%0h seg 0x%0h got 0x%04h, expected 0x%04h",
                row, seg, got, expected));
    endtask

    // row r in the low lane and row r+1 in the high lane, row 15 pairs with row 0
    function automatic logic [BUS_DATA_WIDTH-1:0] shadow_pair(
            input logic [ROW_ADDR_WIDTH-1:0] row, input logic [SEG_ADDR_WIDTH-1:0] seg);
        logic [ROW_ADDR_WIDTH-1:0] upper;
        upper = row + ROW_ADDR_WIDTH'(1);
        return {shadow[upper][seg], shadow[row][seg]};
    endfunction

    task automatic shadow_write(input logic [ROW_ADDR_WIDTH-1:0] row,
            input logic [SEG_ADDR_WIDTH-1:0] seg, input logic [1:0] lanes,
            input logic [BUS_DATA_WIDTH-1:0] data);
        logic [ROW_ADDR_WIDTH-1:0] upper;
        upper = row + ROW_ADDR_WIDTH'(1);
        if (lanes[0]) begin
            shadow[row][seg] = data[SEG_WIDTH-1:0];
        end
        if (lanes[1]) begin
            shadow[upper][seg] = data[BUS_DATA_WIDTH-1:SEG_WIDTH];
        end
    endtask

    // one classic cycle with the request dropped right after ack
    task automatic bus_access(input logic wr, input logic [ROW_ADDR_WIDTH-1:0] row,
            input logic [SEG_ADDR_WIDTH-1:0] seg, input logic [1:0] lanes,
            input logic [BUS_DATA_WIDTH-1:0] data, output logic [BUS_DATA_WIDTH-1:0] rdata);
        int idle;
        @(posedge clock);
        cyc <= 1'b1;
        stb <= 1'b1;
        we <= wr;
        adr <= {row, seg};
        dat_w <= data;
        sel <= lanes;
        wait_ack(idle);
        check_ack_timing(idle);
        rdata = dat_r;
        @(posedge clock);
        cyc <= 1'b0;
        stb <= 1'b0;
        we <= 1'b0;
        check_single_pulse();
    endtask

    // two reads with stb held and one idle cycle expected between the acks
    task automatic held_reads(input logic [ROW_ADDR_WIDTH-1:0] row_a,
            input logic [SEG_ADDR_WIDTH-1:0] seg_a, input logic [ROW_ADDR_WIDTH-1:0] row_b,
            input logic [SEG_ADDR_WIDTH-1:0] seg_b);
        int idle;
        @(posedge clock);
        cyc <= 1'b1;
        stb <= 1'b1;
        we <= 1'b0;
        sel <= 2'b11;
        adr <= {row_a, seg_a};
        wait_ack(idle);
        check_ack_timing(idle);
        check_read(row_a, seg_a, dat_r, shadow_pair(row_a, seg_a));
        @(posedge clock);
        adr <= {row_b, seg_b};
        wait_ack(idle);
        check_ack_timing(idle);
        check_read(row_b, seg_b, dat_r, shadow_pair(row_b, seg_b));
        @(posedge clock);
        cyc <= 1'b0;
        stb <= 1'b0;
        check_single_pulse();
    endtask

    initial begin
        logic [BUS_DATA_WIDTH-1:0] rdata;
        logic [31:0] rnd;
        step_t step;
        seed = 32'h8012_3c68;
        clock = 1'b0;
        reset = 1'b1;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = '0;
        dat_w = '0;
        sel = 2'b00;
        for (int r = 0; r < GRID_ROWS; r++) begin
            for (int s = 0; s < SEGS_PER_ROW; s++) begin
                shadow[r][s] = '0;
            end
        end
        repeat (3) @(posedge clock);
        reset <= 1'b0;

        for (int i = 0; i < NUM_STEPS; i++) begin
            step = STEPS[i];
            bus_access(step.we, step.row, step.seg, step.sel, step.wdata, rdata);
            if (step.we) begin
                shadow_write(step.row, step.seg, step.sel, step.wdata);
            end else begin
                check_read(step.row, step.seg, rdata, step.exp_data);
            end
        end

        // back to back reads with the first one across the wrap
        held_reads(4'd15, 3'd6, 4'd4, 3'd2);

        for (int i = 0; i < NUM_RANDOM; i++) begin
            rnd = $random(seed);
            bus_access(rnd[0], rnd[4:1], rnd[7:5], rnd[9:8], rnd[25:10], rdata);
            if (rnd[0]) begin
                shadow_write(rnd[4:1], rnd[7:5], rnd[9:8], rnd[25:10]);
            end else begin
                check_read(rnd[4:1], rnd[7:5], rdata, shadow_pair(rnd[4:1], rnd[7:5]));
            end
        end

        $display("Test passed");
        $finish;
    end

endmodule

// ==== sim.f ====
rtl/grid_pkg.sv
rtl/bank_if.sv
rtl/segment_ram.sv
rtl/row_bank.sv
rtl/pair_combiner.sv
rtl/grid_store_top.sv
tb/grid_store_asserts.sv
tb/grid_store_tb.sv

// ==== Makefile ====
# Verilator build and run for the grid store testbench

VERILATOR ?= verilator
TOP ?= grid_store_tb
BUILD_DIR ?= obj_dir
FILE_LIST ?= sim.f
VFLAGS ?= --binary --assert -j 0
PASS_TEXT ?= Test passed

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILE_LIST))

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

# status comes from the search for the pass line
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
